// File: verilog/acq_pkg.sv
// shared constants for the multimeter control FPGA
// register map, output word layout and SPI frame format
// SPI frame is 32 bits, MSB first: write flag, 7 bit address, 24 bit data
// no timescale here, package holds definitions only

package acq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame and register widths
  localparam int FRAME_W    = 32;
  localparam int ADDR_W     = 7;
  localparam int DATA_W     = 24;

  localparam int MODE_W     = 3;   // mode field
  localparam int SEQ_W      = 6;   // {pc_sw[1:0], azmux[3:0]}
  localparam int SEQ_IDX_W  = 2;   // up to four steps
  localparam int SEQ_N_W    = 3;
  localparam int HW_FLAGS_W = 4;

  // spi frame, raw shift word or decoded fields
  typedef union packed {
    logic [FRAME_W-1:0] raw;
    struct packed {
      logic              wr;     // bit 31
      logic [ADDR_W-1:0] addr;   // bits 30..24
      logic [DATA_W-1:0] data;   // bits 23..0
    } f;
  } acq_frame_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  localparam logic [ADDR_W-1:0] REG_MODE      = 7'd0;
  localparam logic [ADDR_W-1:0] REG_DIRECT    = 7'd1;
  localparam logic [ADDR_W-1:0] REG_PRECHARGE = 7'd2;
  localparam logic [ADDR_W-1:0] REG_APERTURE  = 7'd3;
  localparam logic [ADDR_W-1:0] REG_SEQ_N     = 7'd4;
  localparam logic [ADDR_W-1:0] REG_SEQ0      = 7'd5;
  localparam logic [ADDR_W-1:0] REG_SEQ1      = 7'd6;
  localparam logic [ADDR_W-1:0] REG_SEQ2      = 7'd7;
  localparam logic [ADDR_W-1:0] REG_SEQ3      = 7'd8;
  localparam logic [ADDR_W-1:0] REG_TRIG      = 7'd9;   // bit 0 runs the sequencer
  localparam logic [ADDR_W-1:0] REG_STATUS    = 7'd10;  // read only

  localparam logic [MODE_W-1:0] MODE_DIRECT   = 3'd0;
  localparam logic [MODE_W-1:0] MODE_SEQ_MOCK = 3'd6;

  localparam logic [7:0] STATUS_MAGIC = 8'b10101010;
  localparam logic [2:0] CS_FPGA      = 3'b001;   // vector value selecting us

  ////////////////////////////////////////////////////////////////////////////
  // board output word, direct register uses the same layout
  localparam int OUT_W       = 19;
  localparam int LEDS_W      = 4;
  localparam int MONITOR_W   = 8;
  localparam int PC_SW_W     = 2;
  localparam int AZMUX_W     = 4;
  localparam int LEDS_LSB    = 0;
  localparam int MONITOR_LSB = 4;
  localparam int PC_SW_LSB   = 12;
  localparam int AZMUX_LSB   = 14;
  localparam int IRQ_BIT     = 18;

endpackage

// File: verilog/spi_frame_rx.sv
// SPI slave, mode 0, MSB first, oversampled in the clk domain
// sck half period must be at least 4 clk cycles
// a frame is only passed on when exactly 32 bits were clocked in
// response is loaded when select asserts, so it is the previous frame's read

`timescale 1ns/1ps

module spi_frame_rx
  import acq_pkg::*;
(
  input  logic              clk,
  input  logic              rst_i,
  input  logic              sck_i,
  input  logic              cs_n_i,
  input  logic              sdi_i,
  input  logic [DATA_W-1:0] rd_data_i,
  output logic              sdo_o,
  output logic              frame_valid_o,
  output acq_frame_t        frame_o
);

  logic [2:0] sck_q;    // [1:0] sync, [2] for edge detect
  logic [2:0] cs_n_q;
  logic [1:0] sdi_q;    // same depth as sck, stays aligned

  logic sck_rise;
  logic sck_fall;
  logic cs_assert;
  logic cs_release;
  logic selected;

  logic [FRAME_W-1:0]       shift_in;
  logic [FRAME_W-1:0]       shift_out;
  logic [$clog2(FRAME_W):0] bit_cnt;   // saturates, so 33+ bits never match

  ////////////////////////////////////////////////////////////////////////////
  // synchronizers
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_q  <= '0;    // mode 0 idles low
      cs_n_q <= '1;
      sdi_q  <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck_i};
      cs_n_q <= {cs_n_q[1:0], cs_n_i};
      sdi_q  <= {sdi_q[0], sdi_i};
    end
  end

  assign sck_rise   =  sck_q[1] & ~sck_q[2];
  assign sck_fall   = ~sck_q[1] &  sck_q[2];
  assign cs_assert  = ~cs_n_q[1] &  cs_n_q[2];
  assign cs_release =  cs_n_q[1] & ~cs_n_q[2];
  assign selected   = ~cs_n_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // shift in, count bits, emit frame on release
  always_ff @(posedge clk) begin
    if (rst_i) begin
      bit_cnt       <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= cs_release && (bit_cnt == FRAME_W);
      if (cs_assert) begin
        bit_cnt <= '0;                    // new frame
      end else if (selected && sck_rise && (bit_cnt != '1)) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (selected && sck_rise) begin
      shift_in <= {shift_in[FRAME_W-2:0], sdi_q[1]};
    end
    if (cs_release) begin
      frame_o.raw <= shift_in;            // payload, qualified by frame_valid_o
    end
  end

  // shift out on falling edges, first bit valid before the first rising edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      shift_out <= '0;                    // keeps the pin defined before first frame
    end else if (cs_assert) begin
      shift_out <= {{(FRAME_W-DATA_W){1'b0}}, rd_data_i};
    end else if (selected && sck_fall) begin
      shift_out <= {shift_out[FRAME_W-2:0], 1'b0};
    end
  end

  assign sdo_o = shift_out[FRAME_W-1];

endmodule

// File: verilog/register_bank.sv
// control registers written and read over SPI frames
// writes take effect on the frame_valid cycle
// read data is registered the cycle after, so a read sees a write of the same frame
// status and unknown addresses ignore writes, unknown addresses read zero

`timescale 1ns/1ps

module register_bank
  import acq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  frame_valid_i,
  input  acq_frame_t            frame_i,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  input  logic [SEQ_IDX_W-1:0]  sample_idx_last_i,
  output logic [DATA_W-1:0]     rd_data_o,
  output logic [MODE_W-1:0]     mode_o,
  output logic [DATA_W-1:0]     direct_o,
  output logic [DATA_W-1:0]     precharge_o,
  output logic [DATA_W-1:0]     aperture_o,
  output logic [SEQ_N_W-1:0]    seq_n_o,
  output logic [SEQ_W-1:0]      seq0_o,
  output logic [SEQ_W-1:0]      seq1_o,
  output logic [SEQ_W-1:0]      seq2_o,
  output logic [SEQ_W-1:0]      seq3_o,
  output logic                  run_o
);

  logic [ADDR_W-1:0] rd_addr;   // latched with the frame
  logic              rd_pend;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] rd_mux;

  ////////////////////////////////////////////////////////////////////////////
  // writes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mode_o      <= MODE_DIRECT;
      direct_o    <= '0;
      precharge_o <= '0;
      aperture_o  <= '0;
      seq_n_o     <= '0;
      seq0_o      <= '0;
      seq1_o      <= '0;
      seq2_o      <= '0;
      seq3_o      <= '0;
      run_o       <= 1'b0;
    end else if (frame_valid_i && frame_i.f.wr) begin
      case (frame_i.f.addr)
        REG_MODE:      mode_o      <= frame_i.f.data[MODE_W-1:0];
        REG_DIRECT:    direct_o    <= frame_i.f.data;
        REG_PRECHARGE: precharge_o <= frame_i.f.data;
        REG_APERTURE:  aperture_o  <= frame_i.f.data;
        REG_SEQ_N:     seq_n_o     <= frame_i.f.data[SEQ_N_W-1:0];
        REG_SEQ0:      seq0_o      <= frame_i.f.data[SEQ_W-1:0];
        REG_SEQ1:      seq1_o      <= frame_i.f.data[SEQ_W-1:0];
        REG_SEQ2:      seq2_o      <= frame_i.f.data[SEQ_W-1:0];
        REG_SEQ3:      seq3_o      <= frame_i.f.data[SEQ_W-1:0];
        REG_TRIG:      run_o       <= frame_i.f.data[0];
        default:       ;                 // status and holes
      endcase
    end
  end

  // status word, bits 15..14 and 23..19 spare
  assign status = {5'b0, seq_n_o, 2'b0, sample_idx_last_i, hw_flags_i, STATUS_MAGIC};

  ////////////////////////////////////////////////////////////////////////////
  // read return
  always_comb begin
    case (rd_addr)
      REG_MODE:      rd_mux = {{(DATA_W-MODE_W){1'b0}}, mode_o};
      REG_DIRECT:    rd_mux = direct_o;
      REG_PRECHARGE: rd_mux = precharge_o;
      REG_APERTURE:  rd_mux = aperture_o;
      REG_SEQ_N:     rd_mux = {{(DATA_W-SEQ_N_W){1'b0}}, seq_n_o};
      REG_SEQ0:      rd_mux = {{(DATA_W-SEQ_W){1'b0}}, seq0_o};
      REG_SEQ1:      rd_mux = {{(DATA_W-SEQ_W){1'b0}}, seq1_o};
      REG_SEQ2:      rd_mux = {{(DATA_W-SEQ_W){1'b0}}, seq2_o};
      REG_SEQ3:      rd_mux = {{(DATA_W-SEQ_W){1'b0}}, seq3_o};
      REG_TRIG:      rd_mux = {{(DATA_W-1){1'b0}}, run_o};
      REG_STATUS:    rd_mux = status;
      default:       rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (frame_valid_i) begin
      rd_addr <= frame_i.f.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_pend   <= 1'b0;
      rd_data_o <= '0;                  // first frame after reset returns zero
    end else begin
      rd_pend <= frame_valid_i;
      if (rd_pend) begin
        rd_data_o <= rd_mux;            // after the write has landed
      end
    end
  end

endmodule

// File: verilog/sequence_acquisition.sv
// precharge/aperture sequencer, stands in for the ADC with a mocked measure-valid
// precharge and aperture counts must be nonzero, a zero count wraps to 2^24 cycles
// each step lasts precharge + aperture cycles, N limited to 1..4
// all outputs registered and zero while run is low

`timescale 1ns/1ps

module sequence_acquisition
  import acq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 run_i,
  input  logic [DATA_W-1:0]    precharge_i,
  input  logic [DATA_W-1:0]    aperture_i,
  input  logic [SEQ_N_W-1:0]   seq_n_i,
  input  logic [SEQ_W-1:0]     seq0_i,
  input  logic [SEQ_W-1:0]     seq1_i,
  input  logic [SEQ_W-1:0]     seq2_i,
  input  logic [SEQ_W-1:0]     seq3_i,
  output logic [PC_SW_W-1:0]   pc_sw_o,
  output logic [AZMUX_W-1:0]   azmux_o,
  output logic [LEDS_W-1:0]    leds_o,
  output logic [MONITOR_W-1:0] monitor_o,
  output logic                 meas_valid_o,
  output logic [SEQ_IDX_W-1:0] sample_idx_last_o
);

  // current state
  logic                 running;
  logic                 aperture;   // 0 precharge, 1 aperture
  logic [DATA_W-1:0]    cnt;        // cycles left in phase, minus one
  logic [SEQ_IDX_W-1:0] idx;

  // next state, outputs are registered from these
  logic                 nxt_running;
  logic                 nxt_aperture;
  logic [DATA_W-1:0]    nxt_cnt;
  logic [SEQ_IDX_W-1:0] nxt_idx;
  logic                 nxt_last;     // last aperture cycle

  logic [SEQ_N_W-1:0]   n_lim;
  logic [SEQ_IDX_W-1:0] idx_inc;
  logic [SEQ_W-1:0]     step_word;

  // clamp N to 1..4
  always_comb begin
    if (seq_n_i == '0) begin
      n_lim = 3'd1;
    end else if (seq_n_i > 3'd4) begin
      n_lim = 3'd4;
    end else begin
      n_lim = seq_n_i;
    end
  end

  // wrap at N
  assign idx_inc = ({1'b0, idx} + 3'd1 >= n_lim) ? '0 : idx + 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // two-phase FSM, next state
  always_comb begin
    nxt_running  = 1'b1;
    nxt_aperture = aperture;
    nxt_cnt      = cnt - 1'b1;
    nxt_idx      = idx;
    if (!run_i) begin
      nxt_running  = 1'b0;           // hold idle
      nxt_aperture = 1'b0;
      nxt_cnt      = '0;
      nxt_idx      = '0;
    end else if (!running) begin
      nxt_aperture = 1'b0;           // start at step 0, precharge
      nxt_cnt      = precharge_i - 1'b1;
      nxt_idx      = '0;
    end else if (cnt == '0) begin
      if (!aperture) begin
        nxt_aperture = 1'b1;
        nxt_cnt      = aperture_i - 1'b1;
      end else begin
        nxt_aperture = 1'b0;         // next step
        nxt_cnt      = precharge_i - 1'b1;
        nxt_idx      = idx_inc;
      end
    end
  end

  assign nxt_last = nxt_running & nxt_aperture & (nxt_cnt == '0);

  // word for the step about to be shown
  always_comb begin
    case (nxt_idx)
      2'd0:    step_word = seq0_i;
      2'd1:    step_word = seq1_i;
      2'd2:    step_word = seq2_i;
      default: step_word = seq3_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and outputs
  always_ff @(posedge clk) begin
    if (rst_i) begin
      running           <= 1'b0;
      aperture          <= 1'b0;
      cnt               <= '0;
      idx               <= '0;
      pc_sw_o           <= '0;
      azmux_o           <= '0;
      leds_o            <= '0;
      monitor_o         <= '0;
      meas_valid_o      <= 1'b0;
      sample_idx_last_o <= '0;
    end else begin
      running      <= nxt_running;
      aperture     <= nxt_aperture;
      cnt          <= nxt_cnt;
      idx          <= nxt_idx;
      meas_valid_o <= nxt_last;
      if (nxt_last) begin
        sample_idx_last_o <= nxt_idx;
      end
      if (nxt_running) begin
        azmux_o   <= step_word[AZMUX_W-1:0];
        pc_sw_o   <= nxt_aperture ? step_word[SEQ_W-1 -: PC_SW_W] : '0;  // off in precharge
        leds_o    <= LEDS_W'(1) << nxt_idx;
        monitor_o <= {4'b0, nxt_idx, nxt_aperture, ~nxt_aperture};
      end else begin
        azmux_o   <= '0;
        pc_sw_o   <= '0;
        leds_o    <= '0;
        monitor_o <= '0;
      end
    end
  end

endmodule

// File: verilog/acq_top.sv
// multimeter front end control FPGA, top level
// FPGA is selected by cs vector 001, shared spi lines are parked high then
// mode 0 drives the pins from the direct register, mode 6 from the sequencer
// any other mode holds every output at zero

`timescale 1ns/1ps

module acq_top
  import acq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  sck_i,
  input  logic                  sdi_i,
  input  logic [2:0]            spi_cs_vec_i,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  output logic                  sdo_o,
  output logic                  spi_glb_clk_o,
  output logic                  spi_glb_mosi_o,
  output logic [LEDS_W-1:0]     leds_o,
  output logic [MONITOR_W-1:0]  monitor_o,
  output logic [PC_SW_W-1:0]    pc_sw_o,
  output logic [AZMUX_W-1:0]    azmux_o,
  output logic                  spi_interrupt_o
);

  logic fpga_sel;
  logic cs_n;

  acq_frame_t           frame;
  logic                 frame_valid;
  logic [DATA_W-1:0]    rd_data;
  logic [MODE_W-1:0]    mode;
  logic [DATA_W-1:0]    direct;
  logic [DATA_W-1:0]    precharge;
  logic [DATA_W-1:0]    aperture;
  logic [SEQ_N_W-1:0]   seq_n;
  logic [SEQ_W-1:0]     seq0;
  logic [SEQ_W-1:0]     seq1;
  logic [SEQ_W-1:0]     seq2;
  logic [SEQ_W-1:0]     seq3;
  logic                 run;

  logic [PC_SW_W-1:0]   sa_pc_sw;
  logic [AZMUX_W-1:0]   sa_azmux;
  logic [LEDS_W-1:0]    sa_leds;
  logic [MONITOR_W-1:0] sa_monitor;
  logic                 sa_meas_valid;
  logic [SEQ_IDX_W-1:0] sa_idx_last;

  logic [OUT_W-1:0]     seq_word;
  logic [OUT_W-1:0]     out_word;

  ////////////////////////////////////////////////////////////////////////////
  // spi line gating, silence shared lines while we are addressed
  assign fpga_sel       = (spi_cs_vec_i == CS_FPGA);
  assign spi_glb_clk_o  = fpga_sel ? 1'b1 : sck_i;    // park hi
  assign spi_glb_mosi_o = fpga_sel ? 1'b1 : sdi_i;    // park hi
  assign cs_n           = ~fpga_sel;                  // active lo

  spi_frame_rx i_spi_frame_rx (
    .clk           (clk),
    .rst_i         (rst_i),
    .sck_i         (sck_i),
    .cs_n_i        (cs_n),
    .sdi_i         (sdi_i),
    .rd_data_i     (rd_data),
    .sdo_o         (sdo_o),
    .frame_valid_o (frame_valid),
    .frame_o       (frame)
  );

  register_bank i_register_bank (
    .clk               (clk),
    .rst_i             (rst_i),
    .frame_valid_i     (frame_valid),
    .frame_i           (frame),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sa_idx_last),
    .rd_data_o         (rd_data),
    .mode_o            (mode),
    .direct_o          (direct),
    .precharge_o       (precharge),
    .aperture_o        (aperture),
    .seq_n_o           (seq_n),
    .seq0_o            (seq0),
    .seq1_o            (seq1),
    .seq2_o            (seq2),
    .seq3_o            (seq3),
    .run_o             (run)
  );

  sequence_acquisition i_sequence_acquisition (
    .clk               (clk),
    .rst_i             (rst_i),
    .run_i             (run),            // trig bit 0
    .precharge_i       (precharge),
    .aperture_i        (aperture),
    .seq_n_i           (seq_n),
    .seq0_i            (seq0),
    .seq1_i            (seq1),
    .seq2_i            (seq2),
    .seq3_i            (seq3),
    .pc_sw_o           (sa_pc_sw),
    .azmux_o           (sa_azmux),
    .leds_o            (sa_leds),
    .monitor_o         (sa_monitor),
    .meas_valid_o      (sa_meas_valid),
    .sample_idx_last_o (sa_idx_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // mode select, same layout for direct and sequencer words
  always_comb begin
    seq_word                             = '0;
    seq_word[LEDS_LSB +: LEDS_W]         = sa_leds;
    seq_word[MONITOR_LSB +: MONITOR_W]   = sa_monitor;
    seq_word[PC_SW_LSB +: PC_SW_W]       = sa_pc_sw;
    seq_word[AZMUX_LSB +: AZMUX_W]       = sa_azmux;
    seq_word[IRQ_BIT]                    = sa_meas_valid;   // interrupt per sample
    case (mode)
      MODE_DIRECT:   out_word = direct[OUT_W-1:0];
      MODE_SEQ_MOCK: out_word = seq_word;
      default:       out_word = '0;
    endcase
  end

  assign leds_o          = out_word[LEDS_LSB +: LEDS_W];
  assign monitor_o       = out_word[MONITOR_LSB +: MONITOR_W];
  assign pc_sw_o         = out_word[PC_SW_LSB +: PC_SW_W];
  assign azmux_o         = out_word[AZMUX_LSB +: AZMUX_W];
  assign spi_interrupt_o = out_word[IRQ_BIT];

endmodule

// File: tests/clk_gen.sv
// testbench clock and reset, 8 ns period
// reset held high for the first 10 rising edges

`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_NS      = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;   // released on an edge, like the stimulus
  end

endmodule

// File: tests/tb_acq_assert.sv
// sequencer protocol checks, bound into every sequence_acquisition
// fail_cnt counts failures so the testbench top can stop the run

`timescale 1ns/1ps

module tb_acq_assert
  import acq_pkg::*;
(
  input logic                 clk,
  input logic                 rst_i,
  input logic                 running_i,
  input logic                 meas_valid_i,
  input logic [PC_SW_W-1:0]   pc_sw_i,
  input logic [MONITOR_W-1:0] monitor_i,
  input logic [LEDS_W-1:0]    leds_i
);

  int unsigned fail_cnt = 0;

  // mocked measure-valid is a single cycle strobe
  a_meas_valid_single : assert property (@(posedge clk) disable iff (rst_i)
    meas_valid_i |=> !meas_valid_i)
    else begin
      fail_cnt++;
      $error("meas_valid held high for more than one cycle");
    end

  // switches stay open during precharge
  a_pc_sw_precharge : assert property (@(posedge clk) disable iff (rst_i)
    monitor_i[0] |-> (pc_sw_i == '0))
    else begin
      fail_cnt++;
      $error("pc_sw nonzero while monitor shows precharge");
    end

  a_leds_onehot : assert property (@(posedge clk) disable iff (rst_i)
    running_i |-> $onehot(leds_i))
    else begin
      fail_cnt++;
      $error("leds not one-hot while the sequencer runs");
    end

endmodule

bind sequence_acquisition tb_acq_assert i_tb_acq_assert (
  .clk          (clk),
  .rst_i        (rst_i),
  .running_i    (running),       // internal state flag
  .meas_valid_i (meas_valid_o),
  .pc_sw_i      (pc_sw_o),
  .monitor_i    (monitor_o),
  .leds_i       (leds_o)
);

// File: tests/tb_acq_top.sv
// testbench for acq_top, SPI master with sck half period of 5 clk cycles
// register table applied in a loop, then direct mode and sequencer mode checks
// stops at the first mismatch, every wait has its own cycle limit

`timescale 1ns/1ps

module tb_acq_top
  import acq_pkg::*;
;

  localparam int TBL_N  = 12;
  localparam int SEQ_P  = 3;      // precharge cycles for the sequencer run
  localparam int SEQ_A  = 4;      // aperture cycles
  localparam int PULSES = 7;

  // address, write value, expected readback
  localparam logic [ADDR_W-1:0] TBL_ADDR [TBL_N] = '{
    REG_MODE, REG_DIRECT, REG_PRECHARGE, REG_APERTURE, REG_SEQ_N, REG_SEQ0,
    REG_SEQ1, REG_SEQ2, REG_SEQ3, REG_TRIG, REG_STATUS, 7'h55};
  localparam logic [DATA_W-1:0] TBL_WDATA [TBL_N] = '{
    24'h5A5A5D, 24'hC3A5F1, 24'h123456, 24'hFEDCBA, 24'hABCDE6, 24'h7777A9,
    24'h0000FF, 24'h555555, 24'hAAAAAA, 24'hFFFFFE, 24'hFFFFFF, 24'h123456};
  localparam logic [DATA_W-1:0] TBL_EXP [TBL_N] = '{
    24'h000005, 24'hC3A5F1, 24'h123456, 24'hFEDCBA, 24'h000006, 24'h000029,
    24'h00003F, 24'h000015, 24'h00002A, 24'h000000, 24'h0609AA, 24'h000000};

  logic       clk;
  logic       rst;
  logic       sck;
  logic       sdi;
  logic [2:0] cs_vec;
  logic [3:0] hw_flags;

  logic                 sdo;
  logic                 glb_clk;
  logic                 glb_mosi;
  logic [LEDS_W-1:0]    leds;
  logic [MONITOR_W-1:0] monitor;
  logic [PC_SW_W-1:0]   pc_sw;
  logic [AZMUX_W-1:0]   azmux;
  logic                 spi_irq;
  logic [OUT_W-1:0]     pins;     // pins reassembled in the board word layout

  // sequencer watch state, owned by the negedge monitor
  logic                 seq_watch;
  logic [SEQ_W-1:0]     seq_tbl [4];
  logic [SEQ_IDX_W-1:0] exp_idx;
  logic [SEQ_IDX_W-1:0] last_idx;
  logic                 prev_ap;
  int                   gap_cnt;
  int                   pulse_cnt;
  int                   error_count;

  clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  acq_top i_acq_top (
    .clk             (clk),
    .rst_i           (rst),
    .sck_i           (sck),
    .sdi_i           (sdi),
    .spi_cs_vec_i    (cs_vec),
    .hw_flags_i      (hw_flags),
    .sdo_o           (sdo),
    .spi_glb_clk_o   (glb_clk),
    .spi_glb_mosi_o  (glb_mosi),
    .leds_o          (leds),
    .monitor_o       (monitor),
    .pc_sw_o         (pc_sw),
    .azmux_o         (azmux),
    .spi_interrupt_o (spi_irq)
  );

  assign pins = {spi_irq, azmux, pc_sw, monitor, leds};

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  task automatic abort_run(input string why);
    $display("stopping: %s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_pins(input logic [OUT_W-1:0] exp);
    check_value("leds_o", 32'(leds), 32'(exp[LEDS_LSB +: LEDS_W]));
    check_value("monitor_o", 32'(monitor), 32'(exp[MONITOR_LSB +: MONITOR_W]));
    check_value("pc_sw_o", 32'(pc_sw), 32'(exp[PC_SW_LSB +: PC_SW_W]));
    check_value("azmux_o", 32'(azmux), 32'(exp[AZMUX_LSB +: AZMUX_W]));
    check_value("spi_interrupt_o", 32'(spi_irq), 32'(exp[IRQ_BIT]));
  endtask

  // pins must settle within 8 cycles of the select going away
  task automatic wait_pins(input logic [OUT_W-1:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while ((pins !== exp) && (n < 8)) begin
      @(negedge clk);
      n++;
    end
    check_pins(exp);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst && (n < 40)) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      abort_run("reset never released");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // spi master, mode 0, MSB first
  task automatic spi_xfer(input logic [31:0] word, output logic [31:0] resp);
    logic [4:0] bit_idx;
    bit_idx = 5'd31;
    repeat (10) @(posedge clk);              // idle gap between frames
    cs_vec <= CS_FPGA;
    repeat (6) @(posedge clk);               // response loads on select
    repeat (32) begin
      sdi <= word[bit_idx];
      repeat (5) @(posedge clk);
      resp[bit_idx] = sdo;                   // master samples before rising sck
      sck <= 1'b1;
      repeat (5) @(posedge clk);
      sck <= 1'b0;
      bit_idx = bit_idx - 5'd1;
    end
    repeat (5) @(posedge clk);
    cs_vec <= 3'b000;
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [31:0] resp;
    spi_xfer({1'b1, addr, data}, resp);
  endtask

  // two frames, the second returns what the first addressed
  task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    logic [31:0] resp;
    spi_xfer({1'b0, addr, 24'h0}, resp);
    spi_xfer({1'b0, addr, 24'h0}, data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequencer monitor, steps 0,1,2 repeat with N = 3
  always @(negedge clk) begin
    if (seq_watch) begin
      gap_cnt = gap_cnt + 1;
      if (monitor[1:0] != 2'b00) begin
        if (monitor[0] && prev_ap) begin
          exp_idx = (exp_idx == 2'd2) ? 2'd0 : exp_idx + 2'd1;   // next step
        end
        check_value("monitor_o[3:2]", 32'(monitor[3:2]), 32'(exp_idx));
        check_value("leds_o", 32'(leds), 32'(4'b0001 << exp_idx));
        check_value("azmux_o", 32'(azmux), 32'(seq_tbl[exp_idx][3:0]));
        if (monitor[0]) begin
          check_value("pc_sw_o in precharge", 32'(pc_sw), 32'(0));
        end else begin
          check_value("pc_sw_o in aperture", 32'(pc_sw), 32'(seq_tbl[exp_idx][5:4]));
        end
      end
      prev_ap = monitor[1];
      if (spi_irq) begin
        check_value("monitor_o[1] at interrupt", 32'(monitor[1]), 32'(1));
        if (pulse_cnt > 0) begin
          check_value("interrupt spacing", 32'(gap_cnt), 32'(SEQ_P + SEQ_A));
        end
        gap_cnt   = 0;
        last_idx  = exp_idx;
        pulse_cnt = pulse_cnt + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (i_acq_top.i_sequence_acquisition.i_tb_acq_assert.fail_cnt != 0) begin
      abort_run("a sequencer assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    int unsigned       seed_val;
    logic [31:0]       resp;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] status_exp;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        k;
    logic [2:0]        combo;
    int                n;

    sck         = 1'b0;
    sdi         = 1'b0;
    cs_vec      = 3'b000;
    hw_flags    = 4'h9;
    seq_watch   = 1'b0;
    exp_idx     = '0;
    last_idx    = '0;
    prev_ap     = 1'b0;
    gap_cnt     = 0;
    pulse_cnt   = 0;
    error_count = 0;
    seed_val    = $urandom(32'h2644_c117);
    wait_reset_release();

    // outputs idle after reset, then line gating
    @(negedge clk);
    check_pins('0);
    combo = 3'd0;
    repeat (4) begin
      @(posedge clk);
      sck    <= combo[1];
      sdi    <= combo[0];
      cs_vec <= combo[1] ? 3'b010 : 3'b000;   // two different foreign selects
      @(negedge clk);
      check_value("spi_glb_clk_o", 32'(glb_clk), 32'(combo[1]));
      check_value("spi_glb_mosi_o", 32'(glb_mosi), 32'(combo[0]));
      combo = combo + 3'd1;
    end
    @(posedge clk);
    sck    <= 1'b0;
    sdi    <= 1'b0;
    cs_vec <= CS_FPGA;
    @(negedge clk);
    check_value("spi_glb_clk_o parked", 32'(glb_clk), 32'(1));
    check_value("spi_glb_mosi_o parked", 32'(glb_mosi), 32'(1));
    @(posedge clk);
    cs_vec <= 3'b000;

    spi_xfer({1'b0, REG_STATUS, 24'h0}, resp);
    check_value("first response after reset", resp, 32'h0);

    // register table, status entry expects seq_n 6 and hw flags 9
    for (k = 4'd0; k < 4'd12; k = k + 4'd1) begin
      reg_write(TBL_ADDR[k], TBL_WDATA[k]);
      spi_xfer({1'b0, REG_STATUS, 24'h0}, resp);
      check_value($sformatf("readback of reg %0d", TBL_ADDR[k]), resp, {8'h00, TBL_EXP[k]});
    end

    // direct mode
    reg_write(REG_MODE, 24'(MODE_DIRECT));
    wait_pins(TBL_WDATA[1][OUT_W-1:0]);
    repeat (4) begin
      word = 24'($urandom);
      reg_write(REG_DIRECT, word);
      wait_pins(word[OUT_W-1:0]);
    end
    reg_write(REG_MODE, 24'd3);
    wait_pins('0);
    reg_write(REG_MODE, 24'd7);
    wait_pins('0);

    // sequencer mode
    @(posedge clk);
    hw_flags <= 4'h6;
    reg_write(REG_PRECHARGE, 24'(SEQ_P));
    reg_write(REG_APERTURE, 24'(SEQ_A));
    reg_write(REG_SEQ_N, 24'd3);
    addr = REG_SEQ0;
    for (k = 4'd0; k < 4'd4; k = k + 4'd1) begin
      seq_tbl[k[1:0]] = 6'($urandom);
      reg_write(addr, 24'(seq_tbl[k[1:0]]));
      addr = addr + 7'd1;
    end
    reg_write(REG_MODE, 24'(MODE_SEQ_MOCK));
    wait_pins('0);                           // idle until triggered
    seq_watch = 1'b1;
    reg_write(REG_TRIG, 24'h000001);
    n = 0;
    while ((pulse_cnt < PULSES) && (n < 400)) begin
      @(posedge clk);
      n++;
    end
    if (pulse_cnt < PULSES) begin
      abort_run("sequencer interrupts did not arrive");
    end
    reg_write(REG_TRIG, 24'h000000);
    wait_pins('0);
    seq_watch = 1'b0;

    reg_read(REG_STATUS, resp);
    status_exp        = '0;
    status_exp[7:0]   = 8'b10101010;     // magic byte
    status_exp[11:8]  = 4'h6;            // hw flags driven above
    status_exp[13:12] = last_idx;        // step of the last interrupt seen
    status_exp[18:16] = 3'd3;            // seq_n
    check_value("status after stop", resp, {8'h00, status_exp});

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sim.f
verilog/acq_pkg.sv
verilog/spi_frame_rx.sv
verilog/register_bank.sv
verilog/sequence_acquisition.sv
verilog/acq_top.sv
tests/clk_gen.sv
tests/tb_acq_assert.sv
tests/tb_acq_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds tb_acq_top with Verilator, runs it and scans sim.log for the result
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --top-module tb_acq_top \
  -Mdir obj_dir -o tb_acq_top -f sim.f \
  && ./obj_dir/tb_acq_top +verilator+error+limit+10 > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "Finished with errors" sim.log \
  && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log \
  || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
